//--- Bender.yml
package:
  name: usb_fs_rx

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/usb_rx_pkg.sv
      - src/usb_line_recover.sv
      - src/usb_packet_detect.sv
      - src/usb_pid_crc_check.sv
      - src/usb_payload_deser.sv
      - src/usb_fs_rx.sv
  - target: test
    include_dirs:
      - src
      - tests
    files:
      - tests/usb_fs_rx_tb.sv

//--- build.f
+incdir+src
+incdir+tests
src/usb_rx_pkg.sv
src/usb_line_recover.sv
src/usb_packet_detect.sv
src/usb_pid_crc_check.sv
src/usb_payload_deser.sv
src/usb_fs_rx.sv
tests/usb_fs_rx_tb.sv

//--- src/usb_fs_rx.sv
`timescale 1ns/1ps
`default_nettype none

module usb_fs_rx (
  input  wire                    clk_48mhz,
  input  wire                    reset,
  input  wire                    dp,
  input  wire                    dn,
  output logic                   bit_strobe,
  output logic                   pkt_start,
  output logic                   pkt_end,
  output usb_rx_pkg::rx_result_t result,
  output logic                   rx_data_put,
  output logic [7:0]             rx_data
);

  import usb_rx_pkg::*;

  line_sample_t line_smp;
  rx_bit_t rx_bit;
  logic pid_complete;
  pid_type_e pid_type;
  // fields of the latched packet result
  logic [3:0] res_pid;
  usb_token_u res_token;
  logic res_valid;

  // dp/dn to settled line states and bit timing
  usb_line_recover line_recover0 (
    .clk_48mhz  (clk_48mhz),
    .reset      (reset),
    .dp         (dp),
    .dn         (dn),
    .line       (line_smp),
    .bit_strobe (bit_strobe)
  );

  // sync/eop framing, nrzi and unstuffing
  usb_packet_detect packet_detect0 (
    .clk_48mhz (clk_48mhz),
    .reset     (reset),
    .line      (line_smp),
    .pkt_start (pkt_start),
    .pkt_end   (pkt_end),
    .rx_bit    (rx_bit)
  );

  usb_pid_crc_check pid_crc_check0 (
    .clk_48mhz    (clk_48mhz),
    .reset        (reset),
    .pkt_start    (pkt_start),
    .pkt_end      (pkt_end),
    .rx_bit       (rx_bit),
    .pid_complete (pid_complete),
    .pid_type     (pid_type),
    .pid          (res_pid),
    .valid        (res_valid)
  );

  usb_payload_deser payload_deser0 (
    .clk_48mhz    (clk_48mhz),
    .reset        (reset),
    .pkt_start    (pkt_start),
    .pkt_end      (pkt_end),
    .pid_complete (pid_complete),
    .pid_type     (pid_type),
    .rx_bit       (rx_bit),
    .token        (res_token),
    .rx_data_put  (rx_data_put),
    .rx_data      (rx_data)
  );

  assign result = '{pid: res_pid, token: res_token, valid: res_valid};

endmodule

`default_nettype wire

//--- src/usb_line_recover.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_rx_cfg.svh"

module usb_line_recover (
  input  wire                      clk_48mhz,
  input  wire                      reset,
  input  wire                      dp,
  input  wire                      dn,
  output usb_rx_pkg::line_sample_t line,
  output logic                     bit_strobe
);

  import usb_rx_pkg::*;

  localparam int PHASE_W = $clog2(`USB_SAMPLES_PER_BIT);

  // two stage synchronizer, newest pair in the low bits
  logic [3:0] pair_sync;
  logic [1:0] pair;
  line_state_e line_state;
  logic [PHASE_W-1:0] bit_phase;
  logic mid_bit;

  //////////////////////////////
  // synchronizer

  always_ff @(posedge clk_48mhz) begin
    pair_sync <= {pair_sync[1:0], dp, dn};
  end

  assign pair = pair_sync[3:2];

  //////////////////////////////
  // line state recovery
  // dp and dn may not flip on the same clock, so any change
  // parks the machine in DT for one clock before naming the state

  always_ff @(posedge clk_48mhz) begin
    if (reset) begin
      line_state <= LS_DT;
    end else if (line_state == LS_DT) begin
      // settled codes equal the pair itself
      line_state <= line_state_e'({1'b0, pair});
    end else if (pair != line_state[1:0]) begin
      line_state <= LS_DT;
    end
  end

  //////////////////////////////
  // bit phase
  // every transition realigns the phase to the sender's bit edge

  always_ff @(posedge clk_48mhz) begin
    if (reset || line_state == LS_DT) begin
      bit_phase <= '0;
    end else begin
      bit_phase <= bit_phase + 1'b1;
    end
  end

  // phase 1 is mid-bit, skip it if the pair has just moved again
  assign mid_bit = (bit_phase == PHASE_W'(1)) && (line_state != LS_DT);
  assign bit_strobe = (bit_phase == PHASE_W'(2));

  assign line = '{state: line_state, valid: mid_bit};

  // only the five defined codes ever appear
  a_state_legal: assert property (@(posedge clk_48mhz) disable iff (reset)
    line_state inside {LS_DT, LS_J, LS_K, LS_SE0, LS_SE1});

endmodule

`default_nettype wire

//--- src/usb_packet_detect.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_rx_cfg.svh"

module usb_packet_detect (
  input  wire                      clk_48mhz,
  input  wire                      reset,
  input  wire usb_rx_pkg::line_sample_t line,
  output logic                     pkt_start,
  output logic                     pkt_end,
  output usb_rx_pkg::rx_bit_t      rx_bit
);

  import usb_rx_pkg::*;

  // last three settled states as {dp, dn} codes, oldest on top
  logic [5:0] history;
  logic [5:0] window;
  logic [1:0] cur;
  logic [1:0] prev;
  logic packet_open;
  logic cur_jk;
  logic prev_jk;
  logic raw_valid;
  logic raw_bit;
  logic stuffed;
  // ones seen in a row, the bit after six is a stuffed zero
  logic [2:0] ones_run;

  assign cur = line.state[1:0];
  assign prev = history[1:0];
  // window includes the sample being taken now
  assign window = {history[3:0], cur};

  //////////////////////////////
  // sync and eop detection

  assign pkt_start = line.valid && !packet_open && (window == `USB_SYNC_PATTERN);
  // second se0 sample in a row closes the packet
  assign pkt_end = line.valid && packet_open && (line.state == LS_SE0) &&
                   (prev == 2'b00);

  always_ff @(posedge clk_48mhz) begin
    if (reset) begin
      // idle line is J
      history <= 6'b101010;
      packet_open <= 1'b0;
    end else begin
      if (line.valid) begin
        history <= window;
      end
      if (pkt_start) begin
        packet_open <= 1'b1;
      end else if (pkt_end) begin
        packet_open <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // nrzi decode
  // same state as the last bit is a 1, a change is a 0
  // the first pid bit is taken against the final K of sync

  assign cur_jk = (line.state == LS_J) || (line.state == LS_K);
  // J and K are the only codes with one wire high
  assign prev_jk = prev[1] ^ prev[0];
  assign raw_valid = packet_open && line.valid && cur_jk && prev_jk;
  assign raw_bit = (cur == prev);

  //////////////////////////////
  // bit unstuffing

  assign stuffed = (ones_run == 3'd6);

  always_ff @(posedge clk_48mhz) begin
    if (reset || pkt_end) begin
      ones_run <= '0;
    end else if (raw_valid) begin
      // stuffed bit restarts the run whatever its value
      if (stuffed || !raw_bit) begin
        ones_run <= '0;
      end else begin
        ones_run <= ones_run + 3'd1;
      end
    end
  end

  assign rx_bit = '{data: raw_bit, valid: raw_valid && !stuffed};

  a_start_end_apart: assert property (@(posedge clk_48mhz) disable iff (reset)
    !(pkt_start && pkt_end));

  // data bits only flow between sync and eop
  a_bit_in_packet: assert property (@(posedge clk_48mhz) disable iff (reset)
    rx_bit.valid |-> packet_open);

endmodule

`default_nettype wire

//--- src/usb_payload_deser.sv
`timescale 1ns/1ps
`default_nettype none

module usb_payload_deser (
  input  wire                        clk_48mhz,
  input  wire                        reset,
  input  wire                        pkt_start,
  input  wire                        pkt_end,
  input  wire                        pid_complete,
  input  wire usb_rx_pkg::pid_type_e pid_type,
  input  wire usb_rx_pkg::rx_bit_t   rx_bit,
  output usb_rx_pkg::usb_token_u     token,
  output logic                       rx_data_put,
  output logic [7:0]                 rx_data
);

  import usb_rx_pkg::*;

  // 11 payload bits behind a sentinel, done when it lands in bit 0
  logic [11:0] token_shift;
  logic token_done;
  // 7 bits behind a sentinel, the 8th bit completes the byte
  logic [7:0] data_shift;
  logic data_en;
  logic byte_done;

  //////////////////////////////
  // token payload

  assign token_done = token_shift[0];

  always_ff @(posedge clk_48mhz) begin
    if (reset || pkt_start) begin
      token_shift <= 12'b1000_0000_0000;
    end else if (rx_bit.valid && pid_complete && (pid_type == PID_TOKEN) && !token_done) begin
      token_shift <= {rx_bit.data, token_shift[11:1]};
    end
  end

  // addr/endp and the sof frame number share these 11 bits
  always_ff @(posedge clk_48mhz) begin
    if (pkt_end && (pid_type == PID_TOKEN)) begin
      token.frame_num <= token_shift[11:1];
    end
  end

  //////////////////////////////
  // data bytes
  // the two crc16 bytes come out like any other byte

  assign data_en = rx_bit.valid && pid_complete && (pid_type == PID_DATA);
  assign byte_done = data_en && data_shift[0];

  always_ff @(posedge clk_48mhz) begin
    if (reset || pkt_start || byte_done) begin
      data_shift <= 8'b1000_0000;
    end else if (data_en) begin
      data_shift <= {rx_bit.data, data_shift[7:1]};
    end
  end

  always_ff @(posedge clk_48mhz) begin
    if (reset) begin
      rx_data_put <= 1'b0;
    end else begin
      rx_data_put <= byte_done;
    end
  end

  // byte holds until the next one completes
  always_ff @(posedge clk_48mhz) begin
    if (byte_done) begin
      rx_data <= {rx_bit.data, data_shift[7:1]};
    end
  end

  a_put_only_data: assert property (@(posedge clk_48mhz) disable iff (reset)
    rx_data_put |-> pid_type == PID_DATA);

endmodule

`default_nettype wire

//--- src/usb_pid_crc_check.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_rx_cfg.svh"

module usb_pid_crc_check (
  input  wire                      clk_48mhz,
  input  wire                      reset,
  input  wire                      pkt_start,
  input  wire                      pkt_end,
  input  wire usb_rx_pkg::rx_bit_t rx_bit,
  output logic                     pid_complete,
  output usb_rx_pkg::pid_type_e    pid_type,
  output logic [3:0]               pid,
  output logic                     valid
);

  import usb_rx_pkg::*;

  // x5 + x2 + 1 and x16 + x15 + x2 + 1, top term implied
  localparam logic [4:0]  CRC5_POLY  = 5'b00101;
  localparam logic [15:0] CRC16_POLY = 16'h8005;

  // 8 pid bits plus a sentinel that walks down to bit 0
  logic [8:0] full_pid;
  logic [4:0] crc5;
  logic [15:0] crc16;
  logic crc_en;
  logic crc5_fb;
  logic crc16_fb;
  logic pid_ok;
  logic crc5_ok;
  logic crc16_ok;
  logic verdict;

  //////////////////////////////
  // pid capture

  always_ff @(posedge clk_48mhz) begin
    if (reset || pkt_start) begin
      full_pid <= 9'b1_0000_0000;
    end else if (rx_bit.valid && !pid_complete) begin
      // lsb first, so new bits enter at the top
      full_pid <= {rx_bit.data, full_pid[8:1]};
    end
  end

  assign pid_complete = full_pid[0];
  assign pid_type = pid_type_e'(full_pid[2:1]);
  // check nibble is the complement of the type nibble
  assign pid_ok = (full_pid[4:1] == ~full_pid[8:5]);

  //////////////////////////////
  // crc checkers
  // both run over every bit after the pid, the packet type
  // decides which one is looked at

  assign crc_en = rx_bit.valid && pid_complete;
  assign crc5_fb = rx_bit.data ^ crc5[4];
  assign crc16_fb = rx_bit.data ^ crc16[15];

  always_ff @(posedge clk_48mhz) begin
    if (reset || pkt_start) begin
      crc5 <= `USB_CRC5_SEED;
      crc16 <= `USB_CRC16_SEED;
    end else if (crc_en) begin
      crc5 <= {crc5[3:0], 1'b0} ^ (crc5_fb ? CRC5_POLY : 5'b0);
      crc16 <= {crc16[14:0], 1'b0} ^ (crc16_fb ? CRC16_POLY : 16'b0);
    end
  end

  assign crc5_ok = (crc5 == `USB_CRC5_RESIDUE);
  assign crc16_ok = (crc16 == `USB_CRC16_RESIDUE);

  //////////////////////////////
  // packet verdict

  always_comb begin
    case (pid_type)
      PID_HANDSHAKE: verdict = 1'b1;
      PID_DATA:      verdict = crc16_ok;
      PID_TOKEN:     verdict = crc5_ok;
      default:       verdict = 1'b0;
    endcase
    // a short packet never reached its sentinel
    verdict = verdict && pid_ok && pid_complete;
  end

  always_ff @(posedge clk_48mhz) begin
    if (reset) begin
      valid <= 1'b0;
    end else if (pkt_end) begin
      valid <= verdict;
    end
  end

  // pid holds until the next eop
  always_ff @(posedge clk_48mhz) begin
    if (pkt_end) begin
      pid <= full_pid[4:1];
    end
  end

endmodule

`default_nettype wire

//--- src/usb_rx_cfg.svh
`ifndef USB_RX_CFG_SVH
`define USB_RX_CFG_SVH

// line samples taken per 12 Mb/s bit at 48 MHz
`define USB_SAMPLES_PER_BIT 4

// tail of sync as three line states J K K, oldest state in the top two bits
// each state is coded by its {dp, dn} pair, J = 2'b10 and K = 2'b01
`define USB_SYNC_PATTERN 6'b100101

// both crcs start from all ones
`define USB_CRC5_SEED 5'b11111
`define USB_CRC16_SEED 16'hffff

// remainder left in the register after a good packet
// including its inverted crc field
`define USB_CRC5_RESIDUE 5'b01100
`define USB_CRC16_RESIDUE 16'h800d

`endif

//--- src/usb_rx_pkg.sv
`default_nettype none

package usb_rx_pkg;

  // settled states carry the {dp, dn} pair in the low two bits
  typedef enum logic [2:0] {
    LS_SE0 = 3'b000,
    LS_K   = 3'b001,
    LS_J   = 3'b010,
    LS_SE1 = 3'b011,
    LS_DT  = 3'b100
  } line_state_e;

  // recovered line state, valid marks the mid-bit sample
  typedef struct packed {
    line_state_e state;
    logic        valid;
  } line_sample_t;

  // one nrzi-decoded, unstuffed bit
  typedef struct packed {
    logic data;
    logic valid;
  } rx_bit_t;

  // pid bits 1:0 give the packet class
  typedef enum logic [1:0] {
    PID_TOKEN     = 2'b01,
    PID_HANDSHAKE = 2'b10,
    PID_DATA      = 2'b11
  } pid_type_e;

  typedef struct packed {
    logic [3:0] endp;
    logic [6:0] addr;
  } token_fields_t;

  // in/out/setup read addr and endp, sof reads the frame number
  typedef union packed {
    token_fields_t fields;
    logic [10:0]   frame_num;
  } usb_token_u;

  typedef struct packed {
    logic [3:0] pid;
    usb_token_u token;
    logic       valid;
  } rx_result_t;

endpackage

`default_nettype wire

//--- tests/usb_tb_model.svh
`ifndef USB_TB_MODEL_SVH
`define USB_TB_MODEL_SVH

// bits of one packet in wire order, pid first and crc last, no sync
logic pkt_bits[$];
// one {dp, dn} code per bit time, sync to idle
logic [1:0] line_codes[$];

//////////////////////////////
// random numbers

// galois form, shifts right, taps for x32 + x22 + x2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
  logic [31:0] next;
  next = {1'b0, state[31:1]};
  if (state[0]) begin
    next = next ^ 32'h8020_0003;
  end
  return next;
endfunction

//////////////////////////////
// crc reference

// x5 + x2 + 1, one bit at a time
function automatic logic [4:0] crc5_next(input logic [4:0] crc, input logic data);
  logic [4:0] next;
  next = {crc[3:0], 1'b0};
  if (data ^ crc[4]) begin
    next = next ^ 5'b00101;
  end
  return next;
endfunction

// x16 + x15 + x2 + 1
function automatic logic [15:0] crc16_next(input logic [15:0] crc, input logic data);
  logic [15:0] next;
  next = {crc[14:0], 1'b0};
  if (data ^ crc[15]) begin
    next = next ^ 16'h8005;
  end
  return next;
endfunction

// fields go out lsb first
task automatic add_bits(input logic [31:0] value, input int width);
  for (int i = 0; i < width; i++) begin
    pkt_bits.push_back(value[i]);
  end
endtask

//////////////////////////////
// line encoder
// sync, then nrzi with a zero stuffed after six ones, then eop and idle J

task automatic encode_packet();
  logic [1:0] level;
  int ones;
  line_codes.delete();
  level = 2'b10;
  // seven zeros and a one, so the tail is K J K K
  for (int i = 0; i < 8; i++) begin
    if (i < 7) begin
      level = ~level;
    end
    line_codes.push_back(level);
  end
  ones = 0;
  foreach (pkt_bits[i]) begin
    // a zero toggles the line, a one holds it
    if (pkt_bits[i]) begin
      ones++;
    end else begin
      level = ~level;
      ones = 0;
    end
    line_codes.push_back(level);
    if (ones == 6) begin
      level = ~level;
      line_codes.push_back(level);
      ones = 0;
    end
  end
  line_codes.push_back(2'b00);
  line_codes.push_back(2'b00);
  // J ends the eop, the rest is idle gap
  repeat (4) line_codes.push_back(2'b10);
endtask

`endif

//--- tests/usb_fs_rx_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_rx_cfg.svh"

module usb_fs_rx_tb;

  import usb_rx_pkg::*;

  localparam int NUM_PACKETS = 200;
  localparam int CLK_PERIOD_NS = 10;
  // budget of 120 bit times per packet, doubled
  localparam int WATCHDOG_NS = NUM_PACKETS * 120 * `USB_SAMPLES_PER_BIT * CLK_PERIOD_NS * 2;

  logic clk_48mhz = 1'b0;
  logic reset;
  logic dp;
  logic dn;
  logic bit_strobe;
  logic pkt_start;
  logic pkt_end;
  rx_result_t result;
  logic rx_data_put;
  logic [7:0] rx_data;

  `include "usb_tb_model.svh"

  logic [31:0] lfsr;
  int errors = 0;
  int starts = 0;
  int ends = 0;
  int results_seen = 0;
  int bytes_seen = 0;
  // scoreboard, kind 0 is addr/endp token, 1 is sof, 2 data, 3 handshake
  logic [7:0] exp_bytes[$];
  rx_result_t exp_results[$];
  int exp_kinds[$];
  logic in_packet = 1'b0;
  logic result_due = 1'b0;
  // clocks since the last bit_strobe, -1 until the first one in a packet
  int strobe_gap = -1;

  always #(CLK_PERIOD_NS / 2) clk_48mhz = ~clk_48mhz;

  usb_fs_rx dut0 (
    .clk_48mhz   (clk_48mhz),
    .reset       (reset),
    .dp          (dp),
    .dn          (dn),
    .bit_strobe  (bit_strobe),
    .pkt_start   (pkt_start),
    .pkt_end     (pkt_end),
    .result      (result),
    .rx_data_put (rx_data_put),
    .rx_data     (rx_data)
  );

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // one lfsr step per bit, lsb of the state is the bit taken
  task automatic take_random(input int width, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < width; i++) begin
      value[i] = lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
  endtask

  //////////////////////////////
  // packet generation

  task automatic build_packet();
    logic [31:0] kind;
    logic [31:0] r;
    logic [31:0] flip;
    logic [31:0] data_byte;
    logic [3:0] pid;
    logic [7:0] pid_byte;
    logic [10:0] payload;
    logic [4:0] crc5;
    logic [15:0] crc16;
    logic [7:0] acc;
    logic pid_bad;
    logic crc_bad;
    logic all_ff;
    int n_bytes;
    rx_result_t exp;
    pkt_bits.delete();
    take_random(2, kind);
    take_random(2, r);
    case (kind[1:0])
      // out, in, setup
      2'd0: pid = (r[1:0] == 2'd2) ? 4'b1101 : {r[0], 3'b001};
      2'd1: pid = 4'b0101;
      2'd2: pid = {r[1:0], 2'b11};
      default: pid = {r[1:0], 2'b10};
    endcase
    pid_byte = {~pid, pid};
    // one packet in eight is damaged, handshakes only in the pid
    take_random(3, r);
    take_random(1, flip);
    pid_bad = (r[2:0] == 3'd0) && (flip[0] || kind[1:0] == 2'd3);
    crc_bad = (r[2:0] == 3'd0) && !pid_bad;
    if (pid_bad) begin
      take_random(2, flip);
      pid_byte[4 + flip[1:0]] = ~pid_byte[4 + flip[1:0]];
    end
    add_bits(pid_byte, 8);
    take_random(11, r);
    payload = r[10:0];
    if (kind[1:0] < 2'd2) begin
      add_bits(payload, 11);
      crc5 = `USB_CRC5_SEED;
      for (int i = 0; i < 11; i++) begin
        crc5 = crc5_next(crc5, payload[i]);
      end
      crc5 = ~crc5;
      take_random(4, flip);
      if (crc_bad) begin
        crc5[flip % 5] = ~crc5[flip % 5];
      end
      // crc field goes out msb first
      for (int i = 4; i >= 0; i--) begin
        pkt_bits.push_back(crc5[i]);
      end
    end else if (kind[1:0] == 2'd2) begin
      take_random(4, r);
      n_bytes = r % 9;
      // a run of 0xff forces stuffed bits
      take_random(2, r);
      all_ff = (r[1:0] == 2'd0);
      crc16 = `USB_CRC16_SEED;
      for (int b = 0; b < n_bytes; b++) begin
        take_random(8, data_byte);
        if (all_ff) begin
          data_byte = 32'hff;
        end
        add_bits(data_byte, 8);
        for (int i = 0; i < 8; i++) begin
          crc16 = crc16_next(crc16, data_byte[i]);
        end
      end
      crc16 = ~crc16;
      take_random(4, flip);
      if (crc_bad) begin
        crc16[flip[3:0]] = ~crc16[flip[3:0]];
      end
      for (int i = 15; i >= 0; i--) begin
        pkt_bits.push_back(crc16[i]);
      end
      // every bit after the pid, crc included, lands in a byte lsb first
      for (int i = 8; i + 8 <= pkt_bits.size(); i += 8) begin
        for (int j = 0; j < 8; j++) begin
          acc[j] = pkt_bits[i + j];
        end
        exp_bytes.push_back(acc);
      end
    end
    exp.pid = pid_byte[3:0];
    exp.token.frame_num = (kind[1:0] < 2'd2) ? payload : 11'd0;
    exp.valid = (pid_byte[7:4] == ~pid_byte[3:0]) && (kind[1:0] == 2'd3 || !crc_bad);
    exp_results.push_back(exp);
    exp_kinds.push_back(int'(kind[1:0]));
  endtask

  // each code is held one bit time, a J/K swap may let one wire lag a clock
  task automatic drive_line();
    logic [1:0] prev;
    logic [31:0] skew;
    logic [31:0] lag_dn;
    prev = {dp, dn};
    foreach (line_codes[i]) begin
      skew = '0;
      lag_dn = '0;
      if ((line_codes[i] ^ prev) == 2'b11) begin
        take_random(1, skew);
        take_random(1, lag_dn);
      end
      for (int c = 0; c < `USB_SAMPLES_PER_BIT; c++) begin
        @(posedge clk_48mhz);
        #1;
        if (c == 0 && skew[0]) begin
          {dp, dn} = lag_dn[0] ? {line_codes[i][1], prev[0]} : {prev[1], line_codes[i][0]};
        end else begin
          {dp, dn} = line_codes[i];
        end
      end
      prev = line_codes[i];
    end
  endtask

  //////////////////////////////
  // scoreboard

  task automatic compare_result();
    rx_result_t exp;
    int kind;
    string tag;
    if (exp_results.size() == 0) begin
      errors++;
      $display("packet end arrived with no packet expected");
    end else begin
      exp = exp_results.pop_front();
      kind = exp_kinds.pop_front();
      tag = $sformatf("packet %0d", results_seen);
      results_seen++;
      check_value({tag, " pid"}, exp.pid, result.pid);
      check_value({tag, " valid"}, exp.valid, result.valid);
      // every byte of the packet is out before eop
      check_value({tag, " bytes missing"}, 0, exp_bytes.size());
      if (kind == 0) begin
        check_value({tag, " addr"}, exp.token.fields.addr, result.token.fields.addr);
        check_value({tag, " endp"}, exp.token.fields.endp, result.token.fields.endp);
      end else if (kind == 1) begin
        check_value({tag, " frame_num"}, exp.token.frame_num, result.token.frame_num);
      end
    end
  endtask

  // outputs settle after the rising edge, so they are read on the falling one
  always @(negedge clk_48mhz) begin
    if (!reset) begin
      if (result_due) begin
        compare_result();
        result_due = 1'b0;
      end
      if (in_packet && strobe_gap >= 0) begin
        strobe_gap++;
      end
      if (in_packet && bit_strobe) begin
        if (strobe_gap >= 0) begin
          check_value("bit_strobe period", `USB_SAMPLES_PER_BIT, strobe_gap);
        end
        strobe_gap = 0;
      end
      if (pkt_start) begin
        starts++;
        if (in_packet) begin
          errors++;
          $display("packet start arrived while the previous packet was still open");
        end
        in_packet = 1'b1;
        strobe_gap = -1;
      end
      if (pkt_end) begin
        ends++;
        if (!in_packet) begin
          errors++;
          $display("packet end arrived with no packet open");
        end
        in_packet = 1'b0;
        result_due = 1'b1;
      end
      if (rx_data_put) begin
        if (exp_bytes.size() == 0) begin
          errors++;
          $display("data byte %0d was put with no byte expected", bytes_seen);
        end else begin
          check_value($sformatf("rx_data byte %0d", bytes_seen), exp_bytes.pop_front(), rx_data);
        end
        bytes_seen++;
      end
    end
  end

  //////////////////////////////
  // main sequence

  initial begin
    lfsr = 32'h0b9f_5f69;
    reset = 1'b1;
    dp = 1'b1;
    dn = 1'b0;
    repeat (2) @(posedge clk_48mhz);
    #1;
    reset = 1'b0;
    // idle J so the line machine settles
    repeat (4 * `USB_SAMPLES_PER_BIT) @(posedge clk_48mhz);
    for (int p = 0; p < NUM_PACKETS; p++) begin
      build_packet();
      encode_packet();
      drive_line();
    end
    repeat (8) @(posedge clk_48mhz);
    check_value("pkt_start count", NUM_PACKETS, starts);
    check_value("pkt_end count", NUM_PACKETS, ends);
    check_value("results left over", 0, exp_results.size());
    check_value("bytes left over", 0, exp_bytes.size());
    $display("errors: %0d, packets started %0d, ended %0d, bytes %0d",
             errors, starts, ends, bytes_seen);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout after %0d ns, the packets were not all received", WATCHDOG_NS);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire
